//--- logic/input_pkg.sv
`default_nettype none

package input_pkg;

  // one byte off the ps2 wire
  typedef logic [7:0] scan_code_t;

  // held movement keys, one bit each
  typedef logic [3:0] key_mask_t;

  // bit positions inside key_mask_t
  localparam int key_up_idx    = 0;
  localparam int key_down_idx  = 1;
  localparam int key_left_idx  = 2;
  localparam int key_right_idx = 3;

  // set 2 make codes for the movement keys
  localparam scan_code_t code_w = 8'h1D;
  localparam scan_code_t code_s = 8'h1B;
  localparam scan_code_t code_a = 8'h1C;
  localparam scan_code_t code_d = 8'h23;

  // prefix bytes
  localparam scan_code_t code_break    = 8'hF0;
  localparam scan_code_t code_extended = 8'hE0;

  // ps2 frame is start, 8 data, parity, stop
  localparam int ps2_frame_bits = 11;

endpackage

`default_nettype wire

//--- logic/view_pkg.sv
`default_nettype none

package view_pkg;

  localparam int coord_width = 12;
  localparam int fps_width   = 10;
  localparam int bcd_digits  = 3;

  // camera coordinate, wraps on overflow
  typedef logic signed [coord_width-1:0] coord_t;

  // frames seen in one window
  typedef logic [fps_width-1:0] fps_t;

  // three packed bcd digits, ones in the low nibble
  typedef logic [4*bcd_digits-1:0] fps_bcd_t;

  // counter saturates here
  localparam fps_t fps_max = '1;

  // largest value three digits can show
  localparam fps_t fps_display_max = fps_t'(999);

endpackage

`default_nettype wire

//--- logic/ps2_receiver.sv
`default_nettype none

module ps2_receiver #(
  parameter int ps2_timeout_cycles = 100_000
) (
  input wire sys_clk,
  input wire sys_rst,
  input wire ps2_clk,
  input wire ps2_data,
  output input_pkg::scan_code_t code,
  output logic code_valid,
  output logic frame_error
);

  import input_pkg::*;

  localparam int idle_width = $clog2(ps2_timeout_cycles + 1);
  localparam logic [3:0] last_bit = 4'(ps2_frame_bits - 1);

  logic [1:0] ps2_clk_sync;
  logic [1:0] ps2_data_sync;
  logic ps2_clk_prev;
  logic clk_fall;
  logic fall_seen;

  logic [3:0] bit_cnt;
  logic [ps2_frame_bits-2:0] shift_reg;
  logic [idle_width-1:0] idle_cnt;
  scan_code_t data_bits;
  logic frame_ok;

  // two flops on each line, idle high
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      ps2_clk_sync  <= 2'b11;
      ps2_data_sync <= 2'b11;
      ps2_clk_prev  <= 1'b1;
      fall_seen     <= 1'b0;
    end else begin
      ps2_clk_sync  <= {ps2_clk_sync[0], ps2_clk};
      ps2_data_sync <= {ps2_data_sync[0], ps2_data};
      ps2_clk_prev  <= ps2_clk_sync[1];
      fall_seen     <= clk_fall;
    end
  end

  assign clk_fall = ps2_clk_prev & ~ps2_clk_sync[1];

  // shift_reg holds start, data, parity once the stop bit arrives
  assign data_bits = shift_reg[8:1];
  assign frame_ok  = !shift_reg[0] && (^shift_reg[9:1]) && ps2_data_sync[1];

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      bit_cnt     <= '0;
      idle_cnt    <= '0;
      code_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      code_valid  <= 1'b0;
      frame_error <= 1'b0;
      if (fall_seen) begin
        idle_cnt <= '0;
        if (bit_cnt == last_bit) begin
          bit_cnt     <= '0;
          code_valid  <= frame_ok;
          frame_error <= !frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (bit_cnt != '0) begin
        // keyboard went quiet mid frame, drop it
        if (idle_cnt == idle_width'(ps2_timeout_cycles - 1)) begin
          bit_cnt  <= '0;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (fall_seen && bit_cnt != last_bit) begin
      shift_reg <= {ps2_data_sync[1], shift_reg[ps2_frame_bits-2:1]};
    end
    if (fall_seen && bit_cnt == last_bit && frame_ok) begin
      code <= data_bits;
    end
  end

  a_valid_error_exclusive: assert property (
    @(posedge sys_clk) disable iff (sys_rst) !(code_valid && frame_error)
  );

endmodule

`default_nettype wire

//--- logic/key_tracker.sv
`default_nettype none

module key_tracker (
  input wire sys_clk,
  input wire sys_rst,
  input wire input_pkg::scan_code_t code,
  input wire code_valid,
  output input_pkg::key_mask_t key_mask
);

  import input_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_after_break,
    st_after_extended
  } state_t;

  state_t state;
  logic ext_break;
  key_mask_t code_bit;
  logic is_prefix;

  // which movement bit this code touches, none if unmapped
  always_comb begin
    code_bit = '0;
    case (code)
      code_w:  code_bit[key_up_idx]    = 1'b1;
      code_s:  code_bit[key_down_idx]  = 1'b1;
      code_a:  code_bit[key_left_idx]  = 1'b1;
      code_d:  code_bit[key_right_idx] = 1'b1;
      default: code_bit = '0;
    endcase
  end

  assign is_prefix = (code == code_break) || (code == code_extended);

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state     <= st_idle;
      ext_break <= 1'b0;
      key_mask  <= '0;
    end else if (code_valid) begin
      case (state)
        st_idle: begin
          if (code == code_break) begin
            state <= st_after_break;
          end else if (code == code_extended) begin
            state <= st_after_extended;
          end else begin
            key_mask <= key_mask | code_bit;
          end
        end
        st_after_break: begin
          if (code == code_extended) begin
            state     <= st_after_extended;
            ext_break <= 1'b1;
          end else if (!is_prefix) begin
            key_mask <= key_mask & ~code_bit;
            state    <= st_idle;
          end
        end
        st_after_extended: begin
          if (code == code_break) begin
            // a second F0 here falls back to a plain break
            if (ext_break) begin
              state <= st_after_break;
            end
            ext_break <= !ext_break;
          end else if (!is_prefix) begin
            // extended keys never move the camera
            state     <= st_idle;
            ext_break <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  a_code_ends_sequence: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    code_valid && !is_prefix |=> state == st_idle
  );

endmodule

`default_nettype wire

//--- logic/camera_control.sv
`default_nettype none

module camera_control (
  input wire sys_clk,
  input wire sys_rst,
  input wire input_pkg::key_mask_t key_mask,
  input wire new_frame,
  output view_pkg::coord_t pos_x,
  output view_pkg::coord_t pos_y
);

  import input_pkg::*;
  import view_pkg::*;

  coord_t step_x;
  coord_t step_y;

  // +1, -1 or 0 along one axis, opposite keys cancel
  function automatic coord_t axis_step(input logic inc, input logic dec);
    coord_t step;
    step = '0;
    if (inc && !dec) begin
      step = coord_t'(1);
    end else if (dec && !inc) begin
      step = coord_t'(-1);
    end
    return step;
  endfunction

  assign step_x = axis_step(key_mask[key_right_idx], key_mask[key_left_idx]);
  assign step_y = axis_step(key_mask[key_up_idx], key_mask[key_down_idx]);

  // one step per rendered frame, wraps in 12 bits
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      pos_x <= '0;
      pos_y <= '0;
    end else if (new_frame) begin
      pos_x <= pos_x + step_x;
      pos_y <= pos_y + step_y;
    end
  end

endmodule

`default_nettype wire

//--- logic/frame_rate_counter.sv
`default_nettype none

module frame_rate_counter #(
  parameter int window_cycles = 50_000_000
) (
  input wire sys_clk,
  input wire sys_rst,
  input wire new_frame,
  output view_pkg::fps_t fps,
  output view_pkg::fps_bcd_t fps_bcd
);

  import view_pkg::*;

  localparam int win_width = (window_cycles > 1) ? $clog2(window_cycles) : 1;
  localparam int bcd_width = $bits(fps_bcd_t);

  logic [win_width-1:0] win_cnt;
  logic win_wrap;
  fps_t frame_cnt;
  fps_t frame_cnt_next;
  fps_t conv_load;

  logic conv_busy;
  logic [3:0] conv_step;
  fps_t conv_bin;
  fps_bcd_t conv_bcd;
  fps_bcd_t conv_bcd_adj;

  assign win_wrap = (win_cnt == win_width'(window_cycles - 1));

  // saturating, a strobe in the wrap cycle still counts
  assign frame_cnt_next = (new_frame && frame_cnt != fps_max) ? frame_cnt + 1'b1 : frame_cnt;

  // display tops out at 999
  assign conv_load = (frame_cnt_next > fps_display_max) ? fps_display_max : frame_cnt_next;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      win_cnt   <= '0;
      frame_cnt <= '0;
      fps       <= '0;
    end else if (win_wrap) begin
      win_cnt   <= '0;
      frame_cnt <= '0;
      fps       <= frame_cnt_next;
    end else begin
      win_cnt   <= win_cnt + 1'b1;
      frame_cnt <= frame_cnt_next;
    end
  end

  // add 3 to any digit of 5 or more before the shift
  always_comb begin
    for (int d = 0; d < bcd_digits; d++) begin
      if (conv_bcd[4*d +: 4] >= 4'd5) begin
        conv_bcd_adj[4*d +: 4] = conv_bcd[4*d +: 4] + 4'd3;
      end else begin
        conv_bcd_adj[4*d +: 4] = conv_bcd[4*d +: 4];
      end
    end
  end

  // ten shift steps, then one cycle to publish
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      conv_busy <= 1'b0;
      conv_step <= '0;
      fps_bcd   <= '0;
    end else if (win_wrap) begin
      conv_busy <= 1'b1;
      conv_step <= '0;
    end else if (conv_busy) begin
      if (conv_step == 4'(fps_width)) begin
        fps_bcd   <= conv_bcd;
        conv_busy <= 1'b0;
      end else begin
        conv_step <= conv_step + 4'd1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (win_wrap) begin
      conv_bin <= conv_load;
      conv_bcd <= '0;
    end else if (conv_busy && conv_step != 4'(fps_width)) begin
      conv_bcd <= {conv_bcd_adj[bcd_width-2:0], conv_bin[fps_width-1]};
      conv_bin <= conv_bin << 1;
    end
  end

  a_bcd_digits_valid: assert property (
    @(posedge sys_clk) disable iff (sys_rst)
    fps_bcd[3:0] <= 4'd9 && fps_bcd[7:4] <= 4'd9 && fps_bcd[11:8] <= 4'd9
  );

endmodule

`default_nettype wire

//--- logic/viewer_input_top.sv
`default_nettype none

module viewer_input_top #(
  parameter int window_cycles      = 50_000_000,
  parameter int ps2_timeout_cycles = 100_000
) (
  input wire sys_clk,
  input wire sys_rst,
  input wire ps2_clk,
  input wire ps2_data,
  input wire new_frame,
  output logic frame_error,
  output view_pkg::coord_t pos_x,
  output view_pkg::coord_t pos_y,
  output view_pkg::fps_t fps,
  output view_pkg::fps_bcd_t fps_bcd
);

  import input_pkg::*;

  scan_code_t code;
  logic code_valid;
  key_mask_t key_mask;

  // keyboard path
  ps2_receiver #(
    .ps2_timeout_cycles(ps2_timeout_cycles)
  ) i_ps2_receiver (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .ps2_clk(ps2_clk),
    .ps2_data(ps2_data),
    .code(code),
    .code_valid(code_valid),
    .frame_error(frame_error)
  );

  key_tracker i_key_tracker (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .code(code),
    .code_valid(code_valid),
    .key_mask(key_mask)
  );

  camera_control i_camera_control (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .key_mask(key_mask),
    .new_frame(new_frame),
    .pos_x(pos_x),
    .pos_y(pos_y)
  );

  // frame status path
  frame_rate_counter #(
    .window_cycles(window_cycles)
  ) i_frame_rate_counter (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .new_frame(new_frame),
    .fps(fps),
    .fps_bcd(fps_bcd)
  );

endmodule

`default_nettype wire

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int fail_count = 0;

task automatic stop_with_failure();
  fail_count++;
  $display(">>> FAIL");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic fail_with_reason(input string why);
  $display("error: %s", why);
  stop_with_failure();
endtask

task automatic check_mask(input string name, input key_mask_t expected, input key_mask_t actual);
  if (actual !== expected) begin
    $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
    stop_with_failure();
  end
endtask

task automatic check_coord(input string name, input coord_t expected, input coord_t actual);
  if (actual !== expected) begin
    $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
    stop_with_failure();
  end
endtask

task automatic check_fps(input string name, input fps_t expected, input fps_t actual);
  if (actual !== expected) begin
    $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
    stop_with_failure();
  end
endtask

task automatic check_bcd(input string name, input fps_bcd_t expected, input fps_bcd_t actual);
  if (actual !== expected) begin
    $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    stop_with_failure();
  end
endtask

`endif

//--- bench/tb_viewer_input_top.sv
`default_nettype none

module tb_viewer_input_top;

  import input_pkg::*;
  import view_pkg::*;

  localparam int clk_period      = 40;
  localparam int window_cycles   = 400;
  localparam int ps2_timeout     = 2000;
  localparam int byte_cycles     = 11 * 40;
  localparam int total_bytes     = 15;
  localparam int total_frames    = 16;
  localparam int frame_cycles    = 3;
  localparam int margin_cycles   = 1000;
  localparam int watchdog_cycles = 16 + total_bytes * byte_cycles
    + total_frames * frame_cycles + 3 * window_cycles + margin_cycles;

  logic sys_clk;
  logic sys_rst;
  logic ps2_clk;
  logic ps2_data;
  logic new_frame;
  logic frame_error;
  coord_t pos_x;
  coord_t pos_y;
  fps_t fps;
  fps_bcd_t fps_bcd;

  int cyc;
  int burst;
  logic got_valid;
  logic got_error;
  key_mask_t model_mask;
  coord_t exp_x;
  coord_t exp_y;
  scan_code_t seq[$];

  `include "tb_checks.svh"

  viewer_input_top #(
    .window_cycles(window_cycles),
    .ps2_timeout_cycles(ps2_timeout)
  ) i_viewer_input_top (
    .sys_clk(sys_clk),
    .sys_rst(sys_rst),
    .ps2_clk(ps2_clk),
    .ps2_data(ps2_data),
    .new_frame(new_frame),
    .frame_error(frame_error),
    .pos_x(pos_x),
    .pos_y(pos_y),
    .fps(fps),
    .fps_bcd(fps_bcd)
  );

  initial begin
    sys_clk = 1'b0;
    forever begin
      #(clk_period / 2) sys_clk = ~sys_clk;
    end
  end

  // cycles since reset release, same phase as the fps window
  always @(posedge sys_clk) begin
    if (sys_rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before all scenarios finished");
    stop_with_failure();
  end

  // key mask after a complete code sequence, starting from idle
  function automatic key_mask_t expect_mask(input key_mask_t mask, input scan_code_t codes[$]);
    key_mask_t result;
    key_mask_t bit_of;
    logic after_break;
    logic after_ext;
    result = mask;
    after_break = 1'b0;
    after_ext = 1'b0;
    foreach (codes[i]) begin
      bit_of = '0;
      case (codes[i])
        code_w:  bit_of[key_up_idx] = 1'b1;
        code_s:  bit_of[key_down_idx] = 1'b1;
        code_a:  bit_of[key_left_idx] = 1'b1;
        code_d:  bit_of[key_right_idx] = 1'b1;
        default: bit_of = '0;
      endcase
      if (codes[i] == code_break) begin
        after_break = 1'b1;
      end else if (codes[i] == code_extended) begin
        after_ext = 1'b1;
      end else begin
        if (!after_ext) begin
          result = after_break ? (result & ~bit_of) : (result | bit_of);
        end
        after_break = 1'b0;
        after_ext = 1'b0;
      end
    end
    return result;
  endfunction

  function automatic coord_t expect_pos(input coord_t pos, input logic inc, input logic dec,
                                        input int frames);
    int step;
    step = 0;
    if (inc && !dec) begin
      step = 1;
    end else if (dec && !inc) begin
      step = -1;
    end
    return coord_t'(int'(pos) + step * frames);
  endfunction

  function automatic fps_bcd_t expect_bcd(input int count);
    return {4'(count / 100 % 10), 4'(count / 10 % 10), 4'(count % 10)};
  endfunction

  task automatic tick();
    @(posedge sys_clk);
    #2;
  endtask

  // host side of one ps2 frame, strobes are watched while it runs
  task automatic send_ps2_byte(input scan_code_t value, input logic bad_parity,
                               output logic valid_seen, output logic error_seen);
    logic [10:0] frame;
    logic parity;
    valid_seen = 1'b0;
    error_seen = 1'b0;
    parity = ~(^value) ^ bad_parity;
    frame = {1'b1, parity, value, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ps2_data = frame[i];
      repeat (10) tick();
      ps2_clk = 1'b0;
      for (int c = 0; c < 20; c++) begin
        tick();
        if (i_viewer_input_top.code_valid) begin
          valid_seen = 1'b1;
        end
        if (frame_error) begin
          error_seen = 1'b1;
        end
      end
      ps2_clk = 1'b1;
      repeat (10) tick();
    end
    ps2_data = 1'b1;
  endtask

  task automatic send_codes(input string name);
    logic valid_seen;
    logic error_seen;
    foreach (seq[i]) begin
      send_ps2_byte(seq[i], 1'b0, valid_seen, error_seen);
      if (!valid_seen || error_seen) begin
        fail_with_reason({name, ": a good frame gave no scan code strobe"});
      end
    end
    model_mask = expect_mask(model_mask, seq);
    check_mask(name, model_mask, i_viewer_input_top.key_mask);
  endtask

  task automatic step_frames(input string name, input int count);
    for (int i = 0; i < count; i++) begin
      new_frame = 1'b1;
      tick();
      new_frame = 1'b0;
      tick();
      tick();
    end
    exp_x = expect_pos(exp_x, model_mask[key_right_idx], model_mask[key_left_idx], count);
    exp_y = expect_pos(exp_y, model_mask[key_up_idx], model_mask[key_down_idx], count);
    check_coord({name, " pos_x"}, exp_x, pos_x);
    check_coord({name, " pos_y"}, exp_y, pos_y);
  endtask

  initial begin
    void'($urandom(32'he070_2c3b));
    sys_rst = 1'b1;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    new_frame = 1'b0;
    model_mask = '0;
    exp_x = '0;
    exp_y = '0;
    repeat (16) @(posedge sys_clk);
    #2;
    sys_rst = 1'b0;
    tick();
    check_mask("reset mask", '0, i_viewer_input_top.key_mask);
    check_coord("reset pos_x", '0, pos_x);
    check_coord("reset pos_y", '0, pos_y);
    check_fps("reset fps", '0, fps);
    check_bcd("reset fps_bcd", '0, fps_bcd);

    seq = '{code_w, code_d};
    send_codes("press w and d");
    step_frames("press w and d", 5);

    seq = '{code_break, code_w};
    send_codes("release w");
    step_frames("release w", 3);
    seq = '{code_a};
    send_codes("press a with d");
    step_frames("a and d cancel", 2);

    seq = '{code_break, code_a, code_w};
    send_codes("back to w and d");
    seq = '{code_extended, code_a};
    send_codes("extended a");
    seq = '{code_extended, code_break, code_w};
    send_codes("extended release w");
    step_frames("after extended codes", 4);

    // parity flipped on an a press, must not reach the mask
    send_ps2_byte(code_a, 1'b1, got_valid, got_error);
    if (!got_error || got_valid) begin
      fail_with_reason("a frame with bad parity was not flagged as a frame error");
    end
    check_mask("bad parity frame", model_mask, i_viewer_input_top.key_mask);
    seq = '{code_s};
    send_codes("good frame after error");
    step_frames("after parity error", 2);

    // burst lands well inside one window
    while (cyc % window_cycles != 0) tick();
    while (cyc % window_cycles != 50) tick();
    burst = int'($urandom % 301);
    for (int i = 0; i < burst; i++) begin
      new_frame = 1'b1;
      tick();
    end
    new_frame = 1'b0;
    while (cyc % window_cycles != 2) tick();
    check_fps("latched fps", fps_t'(burst), fps);
    repeat (13) tick();
    check_bcd("fps in bcd", expect_bcd(burst), fps_bcd);

    if (fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
logic/input_pkg.sv
logic/view_pkg.sv
logic/ps2_receiver.sv
logic/key_tracker.sv
logic/camera_control.sv
logic/frame_rate_counter.sv
logic/viewer_input_top.sv
bench/tb_viewer_input_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_viewer_input_top \
  --Mdir obj_dir -o sim_tb \
  -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF '>>> PASS'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
